// File: Makefile
# Verilator build and run of the CRC accelerator testbench

VERILATOR ?= verilator
TOP       ?= crc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/crc_properties.sv
// Bound assertions on the AHB-Lite slave for wait states, read settling and reset reload
module crc_properties
(
	input logic                      HCLK,
	input logic                      HRESETn,
	input logic                      HSElx,
	input logic [1:0]                HTRANS,
	input logic                      HREADY,
	input logic                      HREADYOUT,
	input logic                      dr_read,
	input logic [crc_pkg::CRC_W-1:0] crc_out,
	input logic                      reset_chain,
	input logic                      reset_pending
);
timeunit 1ns;
timeprecision 100ps;
import crc_pkg::*;

// Failed assertion count
int assert_failures = 0;

////////////////////
// Wait states

// An idle address phase gives a data phase without waits
idle_never_waits: assert property (@(posedge HCLK) disable iff (!HRESETn)
	(HREADY && HREADYOUT && !(HSElx && (HTRANS == HTRANS_NONSEQ))) |=> HREADYOUT)
else
begin
	$error("Wait state inserted with no active data phase");
	assert_failures = assert_failures + 1;
end

// A finished data read sees a CRC that no longer moves
read_settled: assert property (@(posedge HCLK) disable iff (!HRESETn)
	(dr_read && HREADYOUT) |=> $stable(crc_out))
else
begin
	$error("Data read completed while the CRC was still being updated");
	assert_failures = assert_failures + 1;
end

////////////////////
// Reset request

// FSM enters the reload right after a reset request
reset_reloads: assert property (@(posedge HCLK) disable iff (!HRESETn)
	reset_chain |=> reset_pending)
else
begin
	$error("Reset request was not followed by a pending reload");
	assert_failures = assert_failures + 1;
end

endmodule

bind host_interface crc_properties u_props
(
	.HCLK          (HCLK),
	.HRESETn       (HRESETn),
	.HSElx         (HSElx),
	.HTRANS        (HTRANS),
	.HREADY        (HREADY),
	.HREADYOUT     (HREADYOUT),
	.dr_read       (dr_read),
	.crc_out       (crc_out),
	.reset_chain   (reset_chain),
	.reset_pending (reset_pending)
);

// File: bench/crc_stimulus.txt
// Columns: op offset size data expected, all hex; size is HSIZE, offset is the word offset
// op 1 = write, 2 = read and compare word, 3 = read and compare scratch byte, 0 = end
// Reset values of control, polynomial, initial value and data
2 2 2 00000000 00000000
2 5 2 00000000 04C11DB7
2 4 2 00000000 FFFFFFFF
2 0 2 00000000 00000000
// Scratch byte keeps the last write
1 1 0 000000A5 00000000
3 1 2 00000000 000000A5
1 1 0 0000005C 00000000
3 1 2 00000000 0000005C
// CRC-32 MPEG-2 of 123456789, words fill the buffer
1 2 2 00000001 00000000
1 0 2 34333231 00000000
1 0 2 38373635 00000000
1 0 0 00000039 00000000
2 0 2 00000000 0376E6E7
// Output mirror switched on without reload
1 2 2 00000080 00000000
2 2 2 00000000 00000080
2 0 2 00000000 E7676EC0
// Same stream as halfwords and bytes
1 2 2 00000001 00000000
1 0 1 00003231 00000000
1 0 1 00003433 00000000
1 0 0 00000035 00000000
1 0 0 00000036 00000000
1 0 1 00003837 00000000
1 0 0 00000039 00000000
2 0 2 00000000 0376E6E7
// CRC-16 poly 1021 init FFFF
1 5 2 00001021 00000000
1 4 2 0000FFFF 00000000
1 2 2 00000009 00000000
1 0 2 34333231 00000000
1 0 2 38373635 00000000
1 0 0 00000039 00000000
2 0 2 00000000 000029B1
// CRC-8 poly 07 init 0
1 5 2 00000007 00000000
1 4 2 00000000 00000000
1 2 2 00000011 00000000
1 0 1 00003231 00000000
1 0 1 00003433 00000000
1 0 1 00003635 00000000
1 0 1 00003837 00000000
1 0 0 00000039 00000000
2 0 2 00000000 000000F4
// CRC-7 poly 09 init 0
1 5 2 00000009 00000000
1 2 2 00000019 00000000
1 0 2 34333231 00000000
1 0 2 38373635 00000000
1 0 0 00000039 00000000
2 0 2 00000000 00000075
// Reflected CRC-32 by byte reversal in and mirror out
1 5 2 04C11DB7 00000000
1 4 2 FFFFFFFF 00000000
1 2 2 000000A1 00000000
1 0 2 34333231 00000000
1 0 2 38373635 00000000
1 0 0 00000039 00000000
2 0 2 00000000 340BC6D9
// Mirror out off, state unchanged
1 2 2 00000020 00000000
2 0 2 00000000 9B63D02C
// Halfword reversal, lanes swapped in each halfword
1 2 2 000000C1 00000000
1 0 1 00003132 00000000
1 0 1 00003334 00000000
1 0 1 00003536 00000000
1 0 1 00003738 00000000
1 0 0 00003900 00000000
2 0 2 00000000 340BC6D9
// Word reversal, lanes in reverse order
1 2 2 000000E1 00000000
1 0 2 31323334 00000000
1 0 2 35363738 00000000
1 0 0 39000000 00000000
2 0 2 00000000 340BC6D9
0 0 0 00000000 00000000

// File: bench/crc_tb.sv
// Testbench for the CRC accelerator with clock, reset, file-driven AHB master, checks, watchdog
module crc_tb;
timeunit 1ns;
timeprecision 100ps;
import crc_pkg::*;

// Stimulus table with five columns per operation
localparam int MAX_OPS = 128;
localparam int COLS    = 5;

localparam logic [31:0] OP_END       = 32'h0;
localparam logic [31:0] OP_WRITE     = 32'h1;
localparam logic [31:0] OP_READ_WORD = 32'h2;
localparam logic [31:0] OP_READ_BYTE = 32'h3;

// Cycle budget per operation and fixed margin for reset
localparam int OP_CYCLES    = 40;
localparam int MARGIN_CYCLES = 100;

logic        HCLK;
logic        HRESETn;
logic        HSElx;
logic [31:0] HADDR;
logic [1:0]  HTRANS;
logic [2:0]  HSIZE;
logic        HWRITE;
logic [31:0] HWDATA;
logic        HREADY;
logic [31:0] HRDATA;
logic        HREADYOUT;
logic        HRESP;

logic [31:0] stim [MAX_OPS*COLS];
int          num_ops;
int          checks;
int          value_errors;
int          proto_errors;
int          other_errors;

// Single slave, so HREADY follows HREADYOUT
assign HREADY = HREADYOUT;

crc_top #(.BUF_DEPTH(BUF_DEPTH)) UUT (.*);

////////////////////
// Clock
initial HCLK = 1'b0;

always
begin
	#5 HCLK = ~HCLK;
end

////////////////////
// Helpers

// Register name for messages
function automatic string reg_name(input logic [2:0] off);
	case (off)
		REG_DR:   return "data register";
		REG_IDR:  return "scratch register";
		REG_CR:   return "control register";
		REG_INIT: return "initial value register";
		REG_POL:  return "polynomial register";
		default:  return "unmapped offset";
	endcase
endfunction

// One AHB single transfer with inputs changed on the falling edge
task automatic bus_transfer
(
	input  logic        write,
	input  logic [2:0]  off,
	input  logic [2:0]  size,
	input  logic [31:0] wdata,
	output logic [31:0] rdata
);
	@(negedge HCLK);
	HSElx  = 1'b1;
	HADDR  = {27'h0, off, 2'b00};
	HTRANS = HTRANS_NONSEQ;
	HSIZE  = size;
	HWRITE = write;
	// Address phase, previous transfer already done
	@(posedge HCLK);
	@(negedge HCLK);
	HSElx  = 1'b0;
	HTRANS = 2'b00;
	HWDATA = write ? wdata : 32'h0;
	// Data phase lasts until the slave is ready
	while (HREADYOUT !== 1'b1)
	begin
		@(posedge HCLK);
		@(negedge HCLK);
	end
	rdata = HRDATA;
	if (HRESP !== 1'b0)
	begin
		proto_errors++;
		$display("Protocol failure: slave gave an error response at %t", $time);
	end
	@(posedge HCLK);
endtask

// Word result at CRC width
task automatic check_word
(
	input logic [CRC_W-1:0] got,
	input logic [CRC_W-1:0] expected,
	input string            what
);
	checks++;
	if (got !== expected)
	begin
		value_errors++;
		$display("FAIL %t: %s read %h, expected %h", $time, what, got, expected);
	end
endtask

// Scratch byte result
task automatic check_byte
(
	input logic [7:0] got,
	input logic [7:0] expected,
	input string      what
);
	checks++;
	if (got !== expected)
	begin
		value_errors++;
		$display("FAIL %t: %s read %h, expected %h", $time, what, got, expected);
	end
endtask

////////////////////
// Main sequence
initial
begin
	logic [31:0] op;
	logic [31:0] off;
	logic [31:0] size;
	logic [31:0] data;
	logic [31:0] expected;
	logic [31:0] rdata;
	int          count;
	int          assert_fails;
	$timeformat(-9, 1, " ns", 10);
	HRESETn      = 1'b0;
	HSElx        = 1'b0;
	HADDR        = 32'h0;
	HTRANS       = 2'b00;
	HSIZE        = 3'd0;
	HWRITE       = 1'b0;
	HWDATA       = 32'h0;
	num_ops      = 0;
	checks       = 0;
	value_errors = 0;
	proto_errors = 0;
	other_errors = 0;
	$readmemh("bench/crc_stimulus.txt", stim);
	// Table ends at the first zero opcode
	count = 0;
	while ((count < MAX_OPS) && (stim[count*COLS] != OP_END))
		count++;
	num_ops = count;
	if (count == 0)
	begin
		other_errors++;
		$display("No operations were read from the stimulus file");
	end
	// Reset held for 8 cycles
	repeat (8) @(posedge HCLK);
	@(negedge HCLK);
	HRESETn = 1'b1;
	for (int i = 0; i < count; i++)
	begin
		op       = stim[i*COLS];
		off      = stim[i*COLS + 1];
		size     = stim[i*COLS + 2];
		data     = stim[i*COLS + 3];
		expected = stim[i*COLS + 4];
		case (op)
			OP_WRITE:
				bus_transfer(1'b1, off[2:0], size[2:0], data, rdata);
			OP_READ_WORD:
			begin
				bus_transfer(1'b0, off[2:0], size[2:0], 32'h0, rdata);
				check_word(rdata, expected, reg_name(off[2:0]));
			end
			OP_READ_BYTE:
			begin
				bus_transfer(1'b0, off[2:0], size[2:0], 32'h0, rdata);
				check_byte(rdata[7:0], expected[7:0], reg_name(off[2:0]));
			end
			default:
			begin
				other_errors++;
				$display("Stimulus line %0d has an unknown operation code %h", i, op);
			end
		endcase
	end
	assert_fails = UUT.u_host.u_props.assert_failures;
	$display("Checks %0d, errors: value %0d, protocol %0d, other %0d, assertion %0d",
		checks, value_errors, proto_errors, other_errors, assert_fails);
	if ((value_errors + proto_errors + other_errors + assert_fails) == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

////////////////////
// Watchdog scaled by the number of operations
initial
begin
	wait (num_ops > 0);
	repeat (num_ops * OP_CYCLES + MARGIN_CYCLES) @(posedge HCLK);
	$display("Timeout: run did not finish within %0d clock cycles",
		num_ops * OP_CYCLES + MARGIN_CYCLES);
	$display("Simulation failed");
	$finish;
end

endmodule

// File: flist.f
logic/crc_pkg.sv
logic/host_interface.sv
logic/crc_data_buffer.sv
logic/crc_byte_counter.sv
logic/crc_ctrl_fsm.sv
logic/crc_engine.sv
logic/crc_top.sv
bench/crc_properties.sv
bench/crc_tb.sv

// File: logic/crc_byte_counter.sv
// Byte counter for the head buffer entry with last-byte flag
module crc_byte_counter
(
	input  logic       HCLK,
	input  logic       HRESETn,
	input  logic       cnt_load,
	input  logic       cnt_step,
	input  logic [2:0] buf_bytes,
	output logic [1:0] byte_idx,
	output logic       last_byte
);

// Bytes still to feed
logic [2:0] left_q;
// Lane of the next byte
logic [1:0] idx_q;

always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		left_q <= 3'd0;
		idx_q  <= 2'd0;
	end
	else if (cnt_load)
	begin
		left_q <= buf_bytes;
		idx_q  <= 2'd0;
	end
	else if (cnt_step && (left_q != 3'd0))
	begin
		left_q <= left_q - 3'd1;
		idx_q  <= idx_q + 2'd1;
	end
end

assign byte_idx  = idx_q;
assign last_byte = (left_q == 3'd1);

endmodule

// File: logic/crc_ctrl_fsm.sv
// Control FSM: idle, reload and feed states, buffer handshake, busy and reset-pending flags
module crc_ctrl_fsm
(
	input  logic HCLK,
	input  logic HRESETn,
	input  logic reset_chain,
	input  logic buf_valid,
	input  logic last_byte,
	output logic buf_ready,
	output logic cnt_load,
	output logic cnt_step,
	output logic byte_en,
	output logic crc_reload,
	output logic reset_pending,
	output logic read_wait
);

localparam logic [1:0] S_IDLE   = 2'd0;
localparam logic [1:0] S_RELOAD = 2'd1;
localparam logic [1:0] S_FEED   = 2'd2;

logic [1:0] state_q;
logic [1:0] state_d;
// Entry was cut by a reset and still has bytes left
logic       resume_q;

////////////////////
// Next state
always_comb
begin
	state_d = state_q;
	case (state_q)
		S_IDLE:
			if (reset_chain)
				state_d = S_RELOAD;
			else if (buf_valid)
				state_d = S_FEED;
		S_FEED:
			if (reset_chain)
				state_d = S_RELOAD;
			else if (last_byte)
				state_d = S_IDLE;
		S_RELOAD:
			if (!reset_chain)
				state_d = resume_q ? S_FEED : S_IDLE;
		default: state_d = S_IDLE;
	endcase
end

always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		state_q  <= S_IDLE;
		resume_q <= 1'b0;
	end
	else
	begin
		state_q <= state_d;
		// A repeated request during reload keeps the saved position
		if (reset_chain && (state_q != S_RELOAD))
			resume_q <= (state_q == S_FEED) && !last_byte;
	end
end

////////////////////
// Outputs

// Counter loads on the head entry, fed bytes start the next cycle
assign cnt_load   = (state_q == S_IDLE) && buf_valid && !reset_chain;
assign cnt_step   = (state_q == S_FEED);
assign byte_en    = (state_q == S_FEED);
// Pop together with the final byte
assign buf_ready  = (state_q == S_FEED) && last_byte;
assign crc_reload = (state_q == S_RELOAD);

assign reset_pending = reset_chain || (state_q == S_RELOAD);
assign read_wait     = buf_valid || (state_q != S_IDLE);

endmodule

// File: logic/crc_data_buffer.sv
// Circular word FIFO with input bit reversal and per-entry byte count
module crc_data_buffer
#(
	parameter int DEPTH = crc_pkg::BUF_DEPTH
)
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  logic               buffer_write_en,
	input  logic [31:0]        bus_wr,
	input  crc_pkg::bus_size_e bus_size,
	input  crc_pkg::rev_in_e   rev_in_type,
	input  logic               buf_ready,
	output logic               buffer_full,
	output logic               buf_valid,
	output crc_pkg::crc_data_u buf_word,
	output logic [2:0]         buf_bytes
);
import crc_pkg::*;

localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

// Storage, payload only
crc_data_u  word_mem [DEPTH];
logic [2:0] bytes_mem [DEPTH];

logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic [CW-1:0] count;
crc_data_u     din;
logic [2:0]    din_bytes;
logic          push;
logic          pop;

// Held writes are retried here until a slot frees
assign push = buffer_write_en && !buffer_full;
assign pop  = buf_valid && buf_ready;

// Reversal on entry
always_comb
begin
	din.word = bus_wr;
	case (rev_in_type)
		REV_NONE: din.word = bus_wr;
		// Each lane mirrored on its own
		REV_BYTE:
			for (int i = 0; i < 4; i++)
				for (int b = 0; b < 8; b++)
					din.bytes[i][b] = bus_wr[8*i + 7 - b];
		REV_HALF:
			for (int b = 0; b < 16; b++)
			begin
				din.word[b]      = bus_wr[15 - b];
				din.word[16 + b] = bus_wr[31 - b];
			end
		REV_WORD:
			for (int b = 0; b < 32; b++)
				din.word[b] = bus_wr[31 - b];
		default: din.word = bus_wr;
	endcase
end

// Bytes to feed, from the transfer size
always_comb
begin
	case (bus_size)
		BS_BYTE: din_bytes = 3'd1;
		BS_HALF: din_bytes = 3'd2;
		BS_WORD: din_bytes = 3'd4;
		default: din_bytes = 3'd4;
	endcase
end

always_ff @(posedge HCLK)
begin
	if (push)
	begin
		word_mem[wr_ptr]  <= din;
		bytes_mem[wr_ptr] <= din_bytes;
	end
end

// Pointers and fill level
always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end
	else
	begin
		if (push)
			wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end
end

assign buffer_full = (count == CW'(DEPTH));
assign buf_valid   = (count != '0);
assign buf_word    = word_mem[rd_ptr];
assign buf_bytes   = bytes_mem[rd_ptr];

endmodule

// File: logic/crc_engine.sv
// CRC engine: polynomial, initial value, scratch and state registers, byte update, output reversal
module crc_engine
(
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  logic [31:0]               bus_wr,
	input  logic                      crc_init_en,
	input  logic                      crc_poly_en,
	input  logic                      crc_idr_en,
	input  logic                      crc_reload,
	input  logic                      byte_en,
	input  crc_pkg::crc_data_u        buf_word,
	input  logic [1:0]                byte_idx,
	input  crc_pkg::poly_size_e       crc_poly_size,
	input  logic                      rev_out_type,
	output logic [crc_pkg::CRC_W-1:0] crc_out,
	output logic [crc_pkg::CRC_W-1:0] crc_init_out,
	output logic [crc_pkg::CRC_W-1:0] crc_poly_out,
	output logic [7:0]                crc_idr_out
);
import crc_pkg::*;

localparam logic [CRC_W-1:0] POLY_RST = 32'h04C1_1DB7;
localparam logic [CRC_W-1:0] INIT_RST = 32'hFFFF_FFFF;

logic [CRC_W-1:0] poly_q;
logic [CRC_W-1:0] init_q;
logic [CRC_W-1:0] crc_q;
logic [7:0]       idr_q;
logic [CRC_W-1:0] width_mask;
logic [4:0]       msb_pos;
logic [4:0]       rev_shift;
logic [CRC_W-1:0] crc_rev;
logic [7:0]       sel_byte;

// Eight shift steps, MSB of the byte first
function automatic logic [CRC_W-1:0] crc_update
(
	input logic [CRC_W-1:0] crc,
	input logic [7:0]       data,
	input logic [CRC_W-1:0] poly,
	input logic [CRC_W-1:0] mask,
	input logic [4:0]       msb
);
	logic [CRC_W-1:0] c;
	logic             fb;
	c = crc & mask;
	for (int b = 7; b >= 0; b--)
	begin
		fb = c[msb] ^ data[b];
		c = (c << 1) & mask;
		if (fb)
			c = c ^ (poly & mask);
	end
	return c;
endfunction

////////////////////
// Width selection
always_comb
begin
	case (crc_poly_size)
		PS_32:
		begin
			width_mask = 32'hFFFF_FFFF;
			msb_pos    = 5'd31;
		end
		PS_16:
		begin
			width_mask = 32'h0000_FFFF;
			msb_pos    = 5'd15;
		end
		PS_8:
		begin
			width_mask = 32'h0000_00FF;
			msb_pos    = 5'd7;
		end
		default:
		begin
			width_mask = 32'h0000_007F;
			msb_pos    = 5'd6;
		end
	endcase
end

assign sel_byte = buf_word.bytes[byte_idx];

// Configuration registers
always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		poly_q <= POLY_RST;
		init_q <= INIT_RST;
	end
	else
	begin
		if (crc_poly_en)
			poly_q <= bus_wr;
		if (crc_init_en)
			init_q <= bus_wr;
	end
end

// Scratch byte
always_ff @(posedge HCLK)
begin
	if (crc_idr_en)
		idr_q <= bus_wr[7:0];
end

// Running CRC, reload wins over a byte
always_ff @(posedge HCLK)
begin
	if (!HRESETn)
		crc_q <= '0;
	else if (crc_reload)
		crc_q <= init_q & width_mask;
	else if (byte_en)
		crc_q <= crc_update(crc_q, sel_byte, poly_q, width_mask, msb_pos);
end

////////////////////
// Output reversal, full mirror then shifted down to the width
always_comb
begin
	for (int i = 0; i < CRC_W; i++)
		crc_rev[i] = crc_q[CRC_W-1-i];
end

assign rev_shift    = 5'(CRC_W - 1) - msb_pos;
assign crc_out      = rev_out_type ? (crc_rev >> rev_shift) : crc_q;
assign crc_init_out = init_q;
assign crc_poly_out = poly_q;
assign crc_idr_out  = idr_q;

endmodule

// File: logic/crc_pkg.sv
// Package with CRC width, buffer depth, register map, control fields, bus encodings, data union
package crc_pkg;

// Width of the CRC, polynomial and initial-value registers
parameter int CRC_W = 32;

// Default depth of the data buffer in words
parameter int BUF_DEPTH = 2;

////////////////////
// Register map, word offsets from HADDR[4:2]
parameter logic [2:0] REG_DR   = 3'd0;
parameter logic [2:0] REG_IDR  = 3'd1;
parameter logic [2:0] REG_CR   = 3'd2;
parameter logic [2:0] REG_INIT = 3'd4;
parameter logic [2:0] REG_POL  = 3'd5;

// Only this transfer type starts an access
parameter logic [1:0] HTRANS_NONSEQ = 2'b10;

////////////////////
// Control register bit positions
parameter int CR_RESET     = 0;
parameter int CR_POLY_SIZE = 3;
parameter int CR_REV_IN    = 5;
parameter int CR_REV_OUT   = 7;

// Polynomial size
typedef enum logic [1:0] {
	PS_32 = 2'd0,
	PS_16 = 2'd1,
	PS_8  = 2'd2,
	PS_7  = 2'd3
} poly_size_e;

// Bit reversal applied to incoming data
typedef enum logic [1:0] {
	REV_NONE = 2'd0,
	REV_BYTE = 2'd1,
	REV_HALF = 2'd2,
	REV_WORD = 2'd3
} rev_in_e;

// Low bits of HSIZE
typedef enum logic [1:0] {
	BS_BYTE = 2'd0,
	BS_HALF = 2'd1,
	BS_WORD = 2'd2
} bus_size_e;

// One data word, seen whole or as four byte lanes
typedef union packed {
	logic [31:0]     word;
	logic [3:0][7:0] bytes;
} crc_data_u;

endpackage

// File: logic/crc_top.sv
// Top level of the CRC accelerator: AHB-Lite slave, data buffer, byte counter, control FSM, engine
module crc_top
#(
	parameter int BUF_DEPTH = crc_pkg::BUF_DEPTH
)
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);
import crc_pkg::*;

// Bus side
logic [31:0]      bus_wr;
bus_size_e        bus_size;
logic             buffer_write_en;
logic             crc_init_en;
logic             crc_idr_en;
logic             crc_poly_en;
logic             reset_chain;
poly_size_e       crc_poly_size;
rev_in_e          rev_in_type;
logic             rev_out_type;
logic [CRC_W-1:0] crc_out;
logic [CRC_W-1:0] crc_init_out;
logic [CRC_W-1:0] crc_poly_out;
logic [7:0]       crc_idr_out;

// Buffer handshake
logic       buffer_full;
logic       buf_valid;
logic       buf_ready;
crc_data_u  buf_word;
logic [2:0] buf_bytes;

// Sequencing
logic       cnt_load;
logic       cnt_step;
logic [1:0] byte_idx;
logic       last_byte;
logic       byte_en;
logic       crc_reload;
logic       reset_pending;
logic       read_wait;

host_interface u_host (.*);

crc_data_buffer #(.DEPTH(BUF_DEPTH)) u_buffer (.*);

crc_byte_counter u_counter (.*);

crc_ctrl_fsm u_fsm (.*);

crc_engine u_engine (.*);

endmodule

// File: logic/host_interface.sv
// AHB-Lite slave port with address pipeline, register decode, control register, read mux, wait states
module host_interface
(
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  logic                      HSElx,
	input  logic [31:0]               HADDR,
	input  logic [1:0]                HTRANS,
	input  logic [2:0]                HSIZE,
	input  logic                      HWRITE,
	input  logic [31:0]               HWDATA,
	input  logic                      HREADY,
	input  logic [crc_pkg::CRC_W-1:0] crc_out,
	input  logic [crc_pkg::CRC_W-1:0] crc_init_out,
	input  logic [crc_pkg::CRC_W-1:0] crc_poly_out,
	input  logic [7:0]                crc_idr_out,
	input  logic                      buffer_full,
	input  logic                      reset_pending,
	input  logic                      read_wait,
	output logic [31:0]               HRDATA,
	output logic                      HREADYOUT,
	output logic                      HRESP,
	output logic [31:0]               bus_wr,
	output crc_pkg::bus_size_e        bus_size,
	output logic                      buffer_write_en,
	output logic                      crc_init_en,
	output logic                      crc_idr_en,
	output logic                      crc_poly_en,
	output logic                      reset_chain,
	output crc_pkg::poly_size_e       crc_poly_size,
	output crc_pkg::rev_in_e          rev_in_type,
	output logic                      rev_out_type
);
import crc_pkg::*;

// Address phase copies
logic       hsel_q;
logic [1:0] htrans_q;
logic [2:0] haddr_q;
bus_size_e  hsize_q;
logic       hwrite_q;

// Control register fields
poly_size_e poly_size_q;
rev_in_e    rev_in_q;
logic       rev_out_q;

logic        sample_bus;
logic        active;
logic        write_en;
logic        read_en;
logic        dr_read;
logic        cr_write;
logic        init_write;
logic [31:0] cr_rd;

////////////////////
// Address phase pipeline

// New address phase is taken only when the current data phase ends
assign sample_bus = HREADY && HREADYOUT;

always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		hsel_q   <= 1'b0;
		htrans_q <= 2'b00;
	end
	else if (sample_bus)
	begin
		hsel_q   <= HSElx;
		htrans_q <= HTRANS;
	end
end

// Offset, size and direction of the transfer
always_ff @(posedge HCLK)
begin
	if (sample_bus)
	begin
		haddr_q  <= HADDR[4:2];
		hsize_q  <= bus_size_e'(HSIZE[1:0]);
		hwrite_q <= HWRITE;
	end
end

////////////////////
// Data phase decode
assign active   = hsel_q && (htrans_q == HTRANS_NONSEQ);
assign write_en = active && hwrite_q;
assign read_en  = active && !hwrite_q;

assign buffer_write_en = write_en && (haddr_q == REG_DR);
assign crc_idr_en      = write_en && (haddr_q == REG_IDR);
assign cr_write        = write_en && (haddr_q == REG_CR);
assign init_write      = write_en && (haddr_q == REG_INIT);
assign crc_poly_en     = write_en && (haddr_q == REG_POL);
assign dr_read         = read_en && (haddr_q == REG_DR);

// Init value lands only once the pending reload has used the old one
assign crc_init_en = init_write && !reset_pending;

// Write data goes straight through in the data phase
assign bus_wr   = HWDATA;
assign bus_size = hsize_q;

// Wait states for a full buffer, an unsettled CRC or a pending reload
assign HREADYOUT = !((buffer_write_en && buffer_full) ||
	(dr_read && read_wait) ||
	(init_write && reset_pending));

// Always OKAY
assign HRESP = 1'b0;

////////////////////
// Control register
always_ff @(posedge HCLK)
begin
	if (!HRESETn)
	begin
		poly_size_q <= PS_32;
		rev_in_q    <= REV_NONE;
		rev_out_q   <= 1'b0;
	end
	else if (cr_write)
	begin
		poly_size_q <= poly_size_e'(HWDATA[CR_POLY_SIZE +: 2]);
		rev_in_q    <= rev_in_e'(HWDATA[CR_REV_IN +: 2]);
		rev_out_q   <= HWDATA[CR_REV_OUT];
	end
end

// Reset bit is self-clearing and never stored
assign reset_chain = cr_write && HWDATA[CR_RESET];

assign crc_poly_size = poly_size_q;
assign rev_in_type   = rev_in_q;
assign rev_out_type  = rev_out_q;

// Readback view of the control register
always_comb
begin
	cr_rd = 32'h0;
	cr_rd[CR_POLY_SIZE +: 2] = poly_size_q;
	cr_rd[CR_REV_IN +: 2] = rev_in_q;
	cr_rd[CR_REV_OUT] = rev_out_q;
end

// Read mux
always_comb
begin
	case (haddr_q)
		REG_DR:   HRDATA = crc_out;
		REG_IDR:  HRDATA = {24'h0, crc_idr_out};
		REG_CR:   HRDATA = cr_rd;
		REG_INIT: HRDATA = crc_init_out;
		REG_POL:  HRDATA = crc_poly_out;
		default:  HRDATA = 32'h0;
	endcase
end

endmodule
